/* processor.f */
common/processorPkg.sv
verilog/alu.sv
processor/datapath.sv
processor/sequencer.sv
processor/processorTop.sv
testbench/tbMemories.sv
testbench/tbProcessor.sv

/* Bender.yml */
package:
  name: processor

sources:
  - common/processorPkg.sv
  - verilog/alu.sv
  - processor/datapath.sv
  - processor/sequencer.sv
  - processor/processorTop.sv
  - target: test
    files:
      - testbench/tbMemories.sv
      - testbench/tbProcessor.sv

/* testbench/tbProcessor.sv */
`timescale 1ns/1ns

module tbProcessor;

  // Program kinds held in the ROM from address 10
  typedef enum logic [2:0] {pMaths, pBranch, pPrio, pCall, pDerefA, pDerefB} progT;

  // One row of the test table
  typedef struct packed {
    logic [1:0]          irq;
    progT                prog;
    logic [3:0]          code;
    processorPkg::byteT  opA;
    processorPkg::byteT  opB;
    logic                rnd;
    processorPkg::byteT  expAddr;
    processorPkg::byteT  expData;
  } rowT;

  localparam int rowCount   = 27;
  // Reset, idle check after reset, then a budget per row
  localparam int cycleLimit = 10 + 60 + 200 * rowCount;

  logic CLK;
  logic RESET;
  processorPkg::byteT romAddress, romData, busDataIn;
  processorPkg::busReqT busReq;
  logic [processorPkg::irqCount-1:0] irqRaise, irqAck;

  rowT   rows [rowCount];
  string rowNames [rowCount];
  int    rowFill = 0;
  int    errorCount = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  int    seenWrites = 0;
  int    cycleCount = 0;
  logic [31:0] rngState = 32'd24116;

  processorTop uut (
    .CLK        (CLK),
    .RESET      (RESET),
    .romAddress (romAddress),
    .romData    (romData),
    .busDataIn  (busDataIn),
    .busReq     (busReq),
    .irqRaise   (irqRaise),
    .irqAck     (irqAck)
  );

  tbMemories mem (
    .CLK        (CLK),
    .romAddress (romAddress),
    .romData    (romData),
    .busReq     (busReq),
    .busDataIn  (busDataIn)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////
  // Helpers

  function logic [7:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState[7:0];
  endfunction

  // ALU rules worked in full width and then taken modulo 256
  function logic [7:0] expectedAlu(input logic [3:0] code, input logic [7:0] a, b);
    int full;
    case (code)
      4'h0: full = a + b;
      4'h1: full = a - b + 256;
      4'h2: full = a * b;
      4'h3: full = a * 2;
      4'h4: full = a / 2;
      4'h5: full = a + 1;
      4'h6: full = b + 1;
      4'h7: full = a + 255;
      4'h8: full = b + 255;
      4'h9: full = (a == b) ? 1 : 0;
      4'hA: full = (a > b) ? 1 : 0;
      4'hB: full = (a < b) ? 1 : 0;
      default: full = a;
    endcase
    return full % 256;
  endfunction

  task check(input string name, input string what, input logic [7:0] expected, actual);
    if (actual !== expected) begin
      $display("mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
      errorCount++;
    end
  endtask

  task addRow(input string name, input logic [1:0] irq, input progT prog,
              input logic [3:0] code, input logic [7:0] a, b, input logic rnd,
              input logic [7:0] expAddr, expData);
    rowNames[rowFill] = name;
    rows[rowFill]     = '{irq, prog, code, a, b, rnd, expAddr, expData};
    rowFill++;
  endtask

  // End thread everywhere with a high nibble that varies with the address
  task fillMemories();
    logic [7:0] addr;
    for (int i = 0; i < 256; i++) begin
      addr = i[7:0];
      mem.rom[addr] <= {addr[7:4] ^ addr[3:0], 4'hA};
      mem.ram[addr] <= addr ^ 8'h5A;
    end
  endtask

  task loadRow(input progT prog, input logic [3:0] code, input logic [7:0] a, b);
    logic [0:19][7:0] image;
    logic [3:0] brLow;
    // Eq, Gt and Lt compares use the three branch opcodes in turn
    brLow = (code == 4'h9) ? 4'h6 : (code == 4'hA) ? 4'h8 : 4'h7;
    case (prog)
      pMaths:  image = {8'h00, 8'h80, 8'h01, 8'h81, code, 4'h4, 8'h02, 8'h90, {13{8'h0A}}};
      // Taken lands on 1C and writes marker 11, otherwise marker 22
      pBranch: image = {8'h00, 8'h80, 8'h01, 8'h81, code, brLow, 8'h1C, 8'h00, 8'h83,
                        8'h02, 8'h90, 8'h0A, 8'h0A, 8'h00, 8'h82, 8'h02, 8'h90, {4{8'h0A}}};
      // Second thread starts at 20
      pPrio:   image = {8'h00, 8'h80, 8'h02, 8'h90, {12{8'h0A}}, 8'h00, 8'h81, 8'h02, 8'h91};
      // Routine at 20 writes B+1 and the goto at 18 skips the write to 92
      pCall:   image = {8'h00, 8'h80, 8'h01, 8'h81, 8'h0B, 8'h20, 8'h02, 8'h90, 8'h09, 8'h1C,
                        8'h03, 8'h92, 8'h0F, 8'h0A, 8'h0A, 8'h0A, 8'h65, 8'h03, 8'h91, 8'h0C};
      pDerefA: image = {8'h00, 8'h80, 8'h0F, 8'h0D, 8'h02, 8'h90, {14{8'h0A}}};
      default: image = {8'h01, 8'h80, 8'h0E, 8'h03, 8'h90, {15{8'h0A}}};
    endcase
    @(posedge CLK);
    fillMemories();
    for (int i = 0; i < 20; i++) begin
      mem.rom[8'h10 + i] <= image[i];
    end
    mem.rom[processorPkg::irqVector0] <= 8'h10;
    mem.rom[processorPkg::irqVector1] <= (prog == pPrio) ? 8'h20 : 8'h10;
    mem.ram[8'h80] <= a;
    mem.ram[8'h81] <= b;
    // Branch markers
    mem.ram[8'h82] <= 8'h11;
    mem.ram[8'h83] <= 8'h22;
  endtask

  // Hold the lines until the DUT acknowledges from idle
  task startThread(input string name, input logic [1:0] lines);
    logic [1:0] ackExp;
    ackExp = lines[0] ? 2'b01 : 2'b10;
    @(posedge CLK);
    irqRaise <= lines;
    @(negedge CLK);
    while (irqAck == '0) @(negedge CLK);
    check(name, "irqAck", {6'd0, ackExp}, {6'd0, irqAck});
    @(posedge CLK);
    irqRaise <= '0;
  endtask

  task expectWrite(input string name, input logic [7:0] expAddr, expData);
    @(negedge CLK);
    while (mem.writeCount == seenWrites) @(negedge CLK);
    seenWrites++;
    check(name, "write address", expAddr, mem.lastAddr);
    check(name, "write data", expData, mem.lastData);
  endtask

  task reportTest(input string name, input int errorsBefore);
    testsRun++;
    if (errorCount == errorsBefore) begin
      $display("test %s: ok", name);
    end else begin
      testsFailed++;
      $display("test %s: failed", name);
    end
  endtask

  ////////////////////
  // Cycle limit

  initial begin
    while (cycleCount < cycleLimit) begin
      @(posedge CLK);
      cycleCount++;
    end
    $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////
  // Test sequence

  initial begin
    rowT row;
    processorPkg::byteT a, b, expData;
    int errorsBefore;
    RESET    <= 1'b1;
    irqRaise <= '0;
    fillMemories();

    // Name, lines, program, code, operands, random, address, value
    addRow("add", 2'b01, pMaths, 4'h0, 8'h5A, 8'h33, 1'b0, 8'h90, 8'h8D);
    addRow("sub", 2'b10, pMaths, 4'h1, 8'h10, 8'h20, 1'b0, 8'h90, 8'hF0);
    addRow("mul", 2'b01, pMaths, 4'h2, 8'h13, 8'h11, 1'b0, 8'h90, 8'h43);
    addRow("shl", 2'b10, pMaths, 4'h3, 8'hC3, 8'h00, 1'b0, 8'h90, 8'h86);
    addRow("shr", 2'b01, pMaths, 4'h4, 8'hC3, 8'h00, 1'b0, 8'h90, 8'h61);
    addRow("incA", 2'b01, pMaths, 4'h5, 8'hFF, 8'h12, 1'b0, 8'h90, 8'h00);
    addRow("incB", 2'b10, pMaths, 4'h6, 8'h00, 8'h7F, 1'b0, 8'h90, 8'h80);
    addRow("decA", 2'b01, pMaths, 4'h7, 8'h00, 8'h34, 1'b0, 8'h90, 8'hFF);
    addRow("decB", 2'b01, pMaths, 4'h8, 8'h56, 8'h10, 1'b0, 8'h90, 8'h0F);
    addRow("eq", 2'b10, pMaths, 4'h9, 8'h44, 8'h44, 1'b0, 8'h90, 8'h01);
    addRow("gt", 2'b01, pMaths, 4'hA, 8'h90, 8'h20, 1'b0, 8'h90, 8'h01);
    addRow("lt", 2'b01, pMaths, 4'hB, 8'h90, 8'h20, 1'b0, 8'h90, 8'h00);
    addRow("passA", 2'b10, pMaths, 4'hC, 8'h3C, 8'h99, 1'b0, 8'h90, 8'h3C);
    // Random operands take their value from the ALU rules
    addRow("randAdd", 2'b01, pMaths, 4'h0, 8'h00, 8'h00, 1'b1, 8'h90, 8'h00);
    addRow("randSub", 2'b10, pMaths, 4'h1, 8'h00, 8'h00, 1'b1, 8'h90, 8'h00);
    addRow("randMul", 2'b01, pMaths, 4'h2, 8'h00, 8'h00, 1'b1, 8'h90, 8'h00);
    addRow("randDecB", 2'b01, pMaths, 4'h8, 8'h00, 8'h00, 1'b1, 8'h90, 8'h00);
    addRow("brEqTaken", 2'b01, pBranch, 4'h9, 8'h55, 8'h55, 1'b0, 8'h90, 8'h11);
    addRow("brEqNot", 2'b10, pBranch, 4'h9, 8'h55, 8'h56, 1'b0, 8'h90, 8'h22);
    addRow("brGtTaken", 2'b01, pBranch, 4'hA, 8'h80, 8'h7F, 1'b0, 8'h90, 8'h11);
    addRow("brGtNot", 2'b01, pBranch, 4'hA, 8'h7F, 8'h80, 1'b0, 8'h90, 8'h22);
    addRow("brLtTaken", 2'b10, pBranch, 4'hB, 8'h01, 8'h02, 1'b0, 8'h90, 8'h11);
    addRow("brLtNot", 2'b01, pBranch, 4'hB, 8'h02, 8'h02, 1'b0, 8'h90, 8'h22);
    addRow("priority", 2'b11, pPrio, 4'h0, 8'hC1, 8'hD2, 1'b0, 8'h90, 8'hC1);
    addRow("callGoto", 2'b01, pCall, 4'h0, 8'h40, 8'h7F, 1'b0, 8'h91, 8'h80);
    addRow("derefA", 2'b10, pDerefA, 4'h0, 8'h81, 8'h6B, 1'b0, 8'h90, 8'h6B);
    addRow("derefB", 2'b01, pDerefB, 4'h0, 8'h81, 8'hD2, 1'b0, 8'h90, 8'hD2);

    repeat (10) @(posedge CLK);
    RESET <= 1'b0;

    // Reset state before the end thread at 00 sends the core to sleep
    @(negedge CLK);
    check("reset", "write strobe", 8'h00, {7'd0, busReq.writeStrobe});
    check("reset", "irqAck", 8'h00, {6'd0, irqAck});
    check("reset", "bus address", processorPkg::idleBusAddr, busReq.address);
    check("reset", "rom address", 8'h00, romAddress);
    repeat (50) @(negedge CLK);
    check("reset", "write count", 8'h00, mem.writeCount[7:0]);
    reportTest("reset", 0);

    for (int r = 0; r < rowCount; r++) begin
      row          = rows[r];
      errorsBefore = errorCount;
      a            = row.opA;
      b            = row.opB;
      expData      = row.expData;
      if (row.rnd) begin
        a       = nextRandom();
        b       = nextRandom();
        expData = expectedAlu(row.code, a, b);
      end
      loadRow(row.prog, row.code, a, b);
      startThread(rowNames[r], row.irq);
      expectWrite(rowNames[r], row.expAddr, expData);
      // Line 1 alone then starts the thread behind vector FE
      if (row.prog == pPrio) begin
        startThread(rowNames[r], 2'b10);
        expectWrite(rowNames[r], 8'h91, b);
      end
      // After the return, A goes to 90
      if (row.prog == pCall) begin
        expectWrite(rowNames[r], 8'h90, a);
      end
      // No further write may follow, the skipped one included
      repeat (16) @(negedge CLK);
      check(rowNames[r], "write count", seenWrites[7:0], mem.writeCount[7:0]);
      reportTest(rowNames[r], errorsBefore);
    end

    $display("tests: %0d run, %0d failed, %0d mismatches", testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* testbench/tbMemories.sv */
`timescale 1ns/1ns

module tbMemories (
  input  logic                  CLK,
  // Program ROM port
  input  processorPkg::byteT    romAddress,
  output processorPkg::byteT    romData,
  // Data RAM port
  input  processorPkg::busReqT  busReq,
  output processorPkg::byteT    busDataIn
);

  // Contents are loaded by the testbench between threads
  processorPkg::byteT rom [256];
  processorPkg::byteT ram [256];

  ////////////////////
  // Write record

  // Last RAM write seen on the bus
  processorPkg::byteT lastAddr;
  processorPkg::byteT lastData;
  int writeCount = 0;

  initial begin
    romData   = 8'h00;
    busDataIn = 8'h00;
    lastAddr  = 8'h00;
    lastData  = 8'h00;
  end

  ////////////////////
  // Synchronous ports

  // Data leaves one edge after the address
  always @(posedge CLK) begin
    romData   <= rom[romAddress];
    busDataIn <= ram[busReq.address];
    if (busReq.writeStrobe) begin
      ram[busReq.address] <= busReq.writeData;
      lastAddr            <= busReq.address;
      lastData            <= busReq.writeData;
      writeCount          <= writeCount + 1;
    end
  end

endmodule

/* processor/processorTop.sv */
`timescale 1ns/1ns

module processorTop (
  input  logic                               CLK,
  input  logic                               RESET,
  // Program ROM
  output processorPkg::byteT                 romAddress,
  input  processorPkg::byteT                 romData,
  // Data bus
  input  processorPkg::byteT                 busDataIn,
  output processorPkg::busReqT               busReq,
  // Interrupt lines
  input  logic [processorPkg::irqCount-1:0]  irqRaise,
  output logic [processorPkg::irqCount-1:0]  irqAck
);

  // Control from sequencer to datapath
  processorPkg::dpCtrlT dpCtrl;
  // Nonzero ALU result back to the sequencer
  logic aluFlag;

  // Instruction flow and thread control
  sequencer sequencerInst (
    .CLK        (CLK),
    .RESET      (RESET),
    .romData    (romData),
    .irqRaise   (irqRaise),
    .aluFlag    (aluFlag),
    .romAddress (romAddress),
    .irqAck     (irqAck),
    .dpCtrl     (dpCtrl)
  );

  // Registers, ALU and bus request
  datapath datapathInst (
    .CLK       (CLK),
    .RESET     (RESET),
    .dpCtrl    (dpCtrl),
    .romData   (romData),
    .busDataIn (busDataIn),
    .busReq    (busReq),
    .aluFlag   (aluFlag)
  );

endmodule

/* processor/sequencer.sv */
`timescale 1ns/1ns

module sequencer (
  input  logic                               CLK,
  input  logic                               RESET,
  input  processorPkg::byteT                 romData,
  input  logic [processorPkg::irqCount-1:0]  irqRaise,
  input  logic                               aluFlag,
  output processorPkg::byteT                 romAddress,
  output logic [processorPkg::irqCount-1:0]  irqAck,
  output processorPkg::dpCtrlT               dpCtrl
);

  processorPkg::stateT state, stateNext;
  // Program counter and operand offset
  processorPkg::byteT pc, pcNext;
  logic offset, offsetNext;
  // Return address of the last call
  processorPkg::byteT callContext, callContextNext;
  // 0 selects A, 1 selects B
  logic regSelect, regSelectNext;
  logic [processorPkg::irqCount-1:0] irqAckNext;
  processorPkg::opcodeT opcode;

  // ROM returns the word one edge after this address
  assign romAddress = pc + {7'd0, offset};
  assign opcode = processorPkg::opcodeT'(romData[3:0]);

  always_ff @(posedge CLK) begin
    if (RESET) begin
      state       <= processorPkg::sChoose;
      pc          <= '0;
      offset      <= 1'b0;
      callContext <= '0;
      regSelect   <= 1'b0;
      irqAck      <= '0;
    end else begin
      state       <= stateNext;
      pc          <= pcNext;
      offset      <= offsetNext;
      callContext <= callContextNext;
      regSelect   <= regSelectNext;
      irqAck      <= irqAckNext;
    end
  end

  always_comb begin
    stateNext       = state;
    pcNext          = pc;
    // Offset only lives for the cycle after choose
    offsetNext      = 1'b0;
    callContextNext = callContext;
    regSelectNext   = regSelect;
    irqAckNext      = '0;
    dpCtrl          = '0;
    dpCtrl.addrSrc  = processorPkg::addrIdle;
    case (state)
      ////////////////////
      // Thread start
      processorPkg::sIdle: begin
        pcNext = processorPkg::irqVector0;
        // Line 0 has priority
        if (irqRaise[0]) begin
          stateNext     = processorPkg::sThreadWait0;
          irqAckNext[0] = 1'b1;
        end else if (irqRaise[1]) begin
          stateNext     = processorPkg::sThreadWait0;
          pcNext        = processorPkg::irqVector1;
          irqAckNext[1] = 1'b1;
        end
      end
      // Vector address on the ROM
      processorPkg::sThreadWait0: stateNext = processorPkg::sThreadWait1;
      // Vector contents arrive and become the new pc
      processorPkg::sThreadWait1: begin
        stateNext = processorPkg::sThreadWait2;
        pcNext    = romData;
      end
      processorPkg::sThreadWait2: stateNext = processorPkg::sChoose;
      ////////////////////
      // Decode
      processorPkg::sChoose: begin
        offsetNext = 1'b1;
        case (opcode)
          processorPkg::opReadA:     stateNext = processorPkg::sReadA;
          processorPkg::opReadB:     stateNext = processorPkg::sReadB;
          processorPkg::opWriteA:    stateNext = processorPkg::sWriteA;
          processorPkg::opWriteB:    stateNext = processorPkg::sWriteB;
          processorPkg::opMathsA:    stateNext = processorPkg::sMathsA;
          processorPkg::opMathsB:    stateNext = processorPkg::sMathsB;
          processorPkg::opBranchEq,
          processorPkg::opBranchLt,
          processorPkg::opBranchGt:  stateNext = processorPkg::sBranch;
          processorPkg::opGoto:      stateNext = processorPkg::sGoto;
          processorPkg::opEndThread: stateNext = processorPkg::sEnd;
          processorPkg::opCall:      stateNext = processorPkg::sCall;
          processorPkg::opReturn:    stateNext = processorPkg::sReturn;
          processorPkg::opDerefA:    stateNext = processorPkg::sDerefA;
          processorPkg::opDerefB:    stateNext = processorPkg::sDerefB;
          default:                   stateNext = processorPkg::sNop;
        endcase
        // ALU sees real operands only for maths and compares
        dpCtrl.aluEn = opcode inside {[processorPkg::opMathsA : processorPkg::opBranchGt]};
      end
      ////////////////////
      // Read from memory
      processorPkg::sReadA: begin
        stateNext     = processorPkg::sRead0;
        regSelectNext = 1'b0;
      end
      processorPkg::sReadB: begin
        stateNext     = processorPkg::sRead0;
        regSelectNext = 1'b1;
      end
      // Operand byte is the bus address
      processorPkg::sRead0: begin
        stateNext      = processorPkg::sRead1;
        dpCtrl.addrSrc = processorPkg::addrRom;
      end
      // Step past opcode and operand early so the next opcode is ready
      processorPkg::sRead1: begin
        stateNext = processorPkg::sRead2;
        pcNext    = pc + 8'd2;
      end
      processorPkg::sRead2: begin
        stateNext      = processorPkg::sChoose;
        dpCtrl.loadA   = !regSelect;
        dpCtrl.loadB   = regSelect;
        dpCtrl.loadSrc = processorPkg::loadFromBus;
      end
      ////////////////////
      // Write to memory
      processorPkg::sWriteA, processorPkg::sWriteB: begin
        stateNext     = processorPkg::sWrite0;
        regSelectNext = (state == processorPkg::sWriteB);
        pcNext        = pc + 8'd2;
      end
      processorPkg::sWrite0: begin
        stateNext          = processorPkg::sChoose;
        dpCtrl.addrSrc     = processorPkg::addrRom;
        dpCtrl.writeStrobe = 1'b1;
        dpCtrl.writeSrc    = regSelect ? processorPkg::writeFromB : processorPkg::writeFromA;
      end
      ////////////////////
      // Maths loads the result captured during choose
      processorPkg::sMathsA, processorPkg::sMathsB: begin
        stateNext      = processorPkg::sMaths0;
        dpCtrl.loadA   = (state == processorPkg::sMathsA);
        dpCtrl.loadB   = (state == processorPkg::sMathsB);
        dpCtrl.loadSrc = processorPkg::loadFromAlu;
        pcNext         = pc + 8'd1;
      end
      processorPkg::sMaths0: stateNext = processorPkg::sChoose;
      ////////////////////
      // Branch on nonzero compare
      processorPkg::sBranch: begin
        if (aluFlag) begin
          stateNext = processorPkg::sBranch0;
        end else begin
          stateNext = processorPkg::sBranch1;
          pcNext    = pc + 8'd2;
        end
      end
      processorPkg::sBranch0: begin
        stateNext = processorPkg::sBranch1;
        pcNext    = romData;
      end
      processorPkg::sBranch1: stateNext = processorPkg::sChoose;
      ////////////////////
      // Goto, call and return
      processorPkg::sGoto: stateNext = processorPkg::sGoto0;
      processorPkg::sGoto0: begin
        stateNext = processorPkg::sGoto1;
        pcNext    = romData;
      end
      processorPkg::sGoto1: stateNext = processorPkg::sChoose;
      // Return lands after the call's target byte
      processorPkg::sCall: begin
        stateNext       = processorPkg::sCall0;
        callContextNext = pc + 8'd2;
      end
      processorPkg::sCall0: begin
        stateNext = processorPkg::sCall1;
        pcNext    = romData;
      end
      processorPkg::sCall1: stateNext = processorPkg::sChoose;
      processorPkg::sReturn: begin
        stateNext = processorPkg::sReturn0;
        pcNext    = callContext;
      end
      processorPkg::sReturn0: stateNext = processorPkg::sChoose;
      ////////////////////
      // End thread goes back to sleep
      processorPkg::sEnd:  stateNext = processorPkg::sEnd0;
      processorPkg::sEnd0: stateNext = processorPkg::sIdle;
      ////////////////////
      // Dereference uses the register as the address
      processorPkg::sDerefA: begin
        stateNext      = processorPkg::sDeref0;
        regSelectNext  = 1'b0;
        dpCtrl.addrSrc = processorPkg::addrRegA;
      end
      processorPkg::sDerefB: begin
        stateNext      = processorPkg::sDeref0;
        regSelectNext  = 1'b1;
        dpCtrl.addrSrc = processorPkg::addrRegB;
      end
      processorPkg::sDeref0: begin
        stateNext = processorPkg::sDeref1;
        pcNext    = pc + 8'd1;
      end
      processorPkg::sDeref1: begin
        stateNext      = processorPkg::sChoose;
        dpCtrl.loadA   = !regSelect;
        dpCtrl.loadB   = regSelect;
        dpCtrl.loadSrc = processorPkg::loadFromBus;
      end
      // No-op leaves with the offset already on the next byte
      processorPkg::sNop: begin
        stateNext = processorPkg::sChoose;
        pcNext    = pc + 8'd1;
      end
      default: stateNext = processorPkg::sChoose;
    endcase
  end

  // Ack names one line and the thread decodes three cycles later
  assert property (@(posedge CLK) disable iff (RESET)
    (irqAck != '0) |-> $onehot(irqAck) ##3 (state == processorPkg::sChoose));

  assert property (@(posedge CLK) disable iff (RESET)
    state inside {[processorPkg::sChoose : processorPkg::sNop]});

endmodule

/* processor/datapath.sv */
`timescale 1ns/1ns

module datapath (
  input  logic                   CLK,
  input  logic                   RESET,
  input  processorPkg::dpCtrlT   dpCtrl,
  input  processorPkg::byteT     romData,
  input  processorPkg::byteT     busDataIn,
  output processorPkg::busReqT   busReq,
  output logic                   aluFlag
);

  // Working registers
  processorPkg::byteT regA, regB;
  processorPkg::byteT loadValue;
  processorPkg::byteT addrSel;
  processorPkg::byteT aluInA, aluInB, aluResult;

  ////////////////////
  // Registers A and B

  assign loadValue = (dpCtrl.loadSrc == processorPkg::loadFromAlu) ? aluResult : busDataIn;

  always_ff @(posedge CLK) begin
    if (RESET) begin
      regA <= '0;
      regB <= '0;
    end else begin
      if (dpCtrl.loadA) begin
        regA <= loadValue;
      end
      if (dpCtrl.loadB) begin
        regB <= loadValue;
      end
    end
  end

  ////////////////////
  // Bus request

  always_comb begin
    case (dpCtrl.addrSrc)
      processorPkg::addrRom:  addrSel = romData;
      processorPkg::addrRegA: addrSel = regA;
      processorPkg::addrRegB: addrSel = regB;
      default:                addrSel = processorPkg::idleBusAddr;
    endcase
  end

  // Registered, so the address leads the RAM data by one edge
  always_ff @(posedge CLK) begin
    busReq.writeData <= (dpCtrl.writeSrc == processorPkg::writeFromB) ? regB : regA;
    if (RESET) begin
      busReq.address     <= processorPkg::idleBusAddr;
      busReq.writeStrobe <= 1'b0;
    end else begin
      busReq.address     <= addrSel;
      busReq.writeStrobe <= dpCtrl.writeStrobe;
    end
  end

  ////////////////////
  // ALU

  // Operands held at zero outside maths and compares
  assign aluInA = dpCtrl.aluEn ? regA : '0;
  assign aluInB = dpCtrl.aluEn ? regB : '0;

  alu aluInst (
    .CLK    (CLK),
    .RESET  (RESET),
    .inA    (aluInA),
    .inB    (aluInB),
    .aluOp  (processorPkg::aluOpT'(romData[7:4])),
    .result (aluResult)
  );

  assign aluFlag = |aluResult;

  // Writes are spaced by at least one idle cycle
  assert property (@(posedge CLK) disable iff (RESET)
    busReq.writeStrobe |=> !busReq.writeStrobe);

endmodule

/* verilog/alu.sv */
`timescale 1ns/1ns

module alu (
  input  logic                 CLK,
  input  logic                 RESET,
  input  processorPkg::byteT   inA,
  input  processorPkg::byteT   inB,
  input  processorPkg::aluOpT  aluOp,
  output processorPkg::byteT   result
);

  processorPkg::byteT resultNext;

  ////////////////////
  // Operation select

  always_comb begin
    case (aluOp)
      processorPkg::aluAdd:  resultNext = inA + inB;
      processorPkg::aluSub:  resultNext = inA - inB;
      // Low byte of the product
      processorPkg::aluMul:  resultNext = inA * inB;
      processorPkg::aluShl:  resultNext = inA << 1;
      processorPkg::aluShr:  resultNext = inA >> 1;
      processorPkg::aluIncA: resultNext = inA + 8'd1;
      processorPkg::aluIncB: resultNext = inB + 8'd1;
      processorPkg::aluDecA: resultNext = inA - 8'd1;
      processorPkg::aluDecB: resultNext = inB - 8'd1;
      // Compares give 01 or 00
      processorPkg::aluEq:   resultNext = {7'd0, inA == inB};
      processorPkg::aluGt:   resultNext = {7'd0, inA > inB};
      processorPkg::aluLt:   resultNext = {7'd0, inA < inB};
      // Unused codes pass A
      default:               resultNext = inA;
    endcase
  end

  ////////////////////
  // Result register

  // One cycle latency
  always_ff @(posedge CLK) begin
    if (RESET) begin
      result <= '0;
    end else begin
      result <= resultNext;
    end
  end

endmodule

/* common/processorPkg.sv */
package processorPkg;

  ////////////////////
  // Basic types

  // One data or address word
  typedef logic [7:0] byteT;

  // Number of interrupt lines
  parameter int irqCount = 2;

  // Operation codes, low nibble of the instruction byte
  typedef enum logic [3:0] {
    opReadA     = 4'h0,
    opReadB     = 4'h1,
    opWriteA    = 4'h2,
    opWriteB    = 4'h3,
    opMathsA    = 4'h4,
    opMathsB    = 4'h5,
    opBranchEq  = 4'h6,
    opBranchLt  = 4'h7,
    opBranchGt  = 4'h8,
    opGoto      = 4'h9,
    opEndThread = 4'hA,
    opCall      = 4'hB,
    opReturn    = 4'hC,
    opDerefA    = 4'hD,
    opDerefB    = 4'hE,
    opNop       = 4'hF
  } opcodeT;

  // ALU operations, high nibble of the instruction byte
  // Codes C to F fall through to pass A
  typedef enum logic [3:0] {
    aluAdd  = 4'h0,
    aluSub  = 4'h1,
    aluMul  = 4'h2,
    aluShl  = 4'h3,
    aluShr  = 4'h4,
    aluIncA = 4'h5,
    aluIncB = 4'h6,
    aluDecA = 4'h7,
    aluDecB = 4'h8,
    aluEq   = 4'h9,
    aluGt   = 4'hA,
    aluLt   = 4'hB
  } aluOpT;

  ////////////////////
  // Sequencer states

  // Contiguous encoding from sChoose up to sNop
  typedef enum logic [5:0] {
    sChoose,
    sIdle, sThreadWait0, sThreadWait1, sThreadWait2,
    sReadA, sReadB, sRead0, sRead1, sRead2,
    sWriteA, sWriteB, sWrite0,
    sMathsA, sMathsB, sMaths0,
    sBranch, sBranch0, sBranch1,
    sGoto, sGoto0, sGoto1,
    sEnd, sEnd0,
    sCall, sCall0, sCall1,
    sReturn, sReturn0,
    sDerefA, sDerefB, sDeref0, sDeref1,
    sNop
  } stateT;

  ////////////////////
  // Bus and control

  typedef struct packed {
    byteT address;
    byteT writeData;
    logic writeStrobe;
  } busReqT;

  // Source of the bus address
  typedef enum logic [1:0] {
    addrIdle = 2'd0,
    addrRom  = 2'd1,
    addrRegA = 2'd2,
    addrRegB = 2'd3
  } addrSrcT;

  // Register load source and write data source
  parameter logic loadFromBus = 1'b0;
  parameter logic loadFromAlu = 1'b1;
  parameter logic writeFromA  = 1'b0;
  parameter logic writeFromB  = 1'b1;

  // Per-cycle datapath control from the sequencer
  typedef struct packed {
    logic    loadA;
    logic    loadB;
    logic    loadSrc;
    addrSrcT addrSrc;
    logic    writeStrobe;
    logic    writeSrc;
    logic    aluEn;
  } dpCtrlT;

  // ROM words holding the thread start addresses
  parameter byteT irqVector0 = 8'hFF;
  parameter byteT irqVector1 = 8'hFE;

  // Bus address shown when nothing is accessed
  parameter byteT idleBusAddr = 8'hFF;

endpackage
